// ==== build.f ====
rtl/axis_fifo_pkg.sv
rtl/packet_admit_fsm.sv
rtl/fifo_pointers.sv
rtl/packet_ram.sv
rtl/output_stage.sv
rtl/axis_packet_fifo.sv
testbench/tb_axis_packet_fifo.sv

// ==== rtl/axis_fifo_pkg.sv ====
`default_nettype none

package axis_fifo_pkg;

   // Flit field widths
   // 64-bit data bus, one keep bit per byte
   typedef logic [63:0] data_t;
   typedef logic [7:0]  keep_t;

   // Routing side channels
   typedef logic [3:0]  id_t;
   typedef logic [3:0]  dest_t;

   // User side channel, carries the poison flag
   typedef logic [1:0]  user_t;

   // One stored beat, 83 bits
   // Same layout in the buffer and on both streams
   typedef struct packed {
      data_t data;
      keep_t keep;
      id_t   id;
      dest_t dest;
      user_t user;
      logic  last;
   } flit_t;

   // tuser bit that poisons the whole packet
   localparam int ERROR_BIT = 0;

   // Per-packet admission state
   // Idle between packets, store while buffering,
   // discard the tail of a dropped packet
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STORE,
      ST_DISCARD
   } admit_state_t;

endpackage

`default_nettype wire

// ==== rtl/axis_packet_fifo.sv ====
`default_nettype none

module axis_packet_fifo #(
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                  aclk,
   input  logic                  aresetn,

   // Input stream
   input  axis_fifo_pkg::flit_t  in_flit,
   input  logic                  in_valid,
   output logic                  in_ready,

   // Output stream
   output axis_fifo_pkg::flit_t  out_flit,
   output logic                  out_valid,
   input  logic                  out_ready,

   // One pulse per dropped packet
   output logic                  packet_dropped
);

   import axis_fifo_pkg::*;

   // Buffer slot index
   typedef logic [DEPTH_LOG2-1:0] addr_t;

   // Admission to pointers and RAM
   logic  wr_en;
   logic  commit;
   logic  rollback;

   // Pointer status
   logic  full;
   logic  empty;

   // Read side
   logic  fetch;
   addr_t wr_addr;
   addr_t rd_addr;
   flit_t rd_flit;

   // Write-side control, owns in_ready
   packet_admit_fsm u_admit (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .in_valid (in_valid),
      .in_flit  (in_flit),
      .full     (full),
      .ready    (in_ready),
      .wr_en    (wr_en),
      .commit   (commit),
      .rollback (rollback),
      .dropped  (packet_dropped)
   );

   // Speculative, committed and read pointers
   fifo_pointers #(
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) u_pointers (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr_en    (wr_en),
      .commit   (commit),
      .rollback (rollback),
      .fetch    (fetch),
      .wr_addr  (wr_addr),
      .rd_addr  (rd_addr),
      .full     (full),
      .empty    (empty)
   );

   // Flit storage
   packet_ram #(
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) u_ram (
      .aclk    (aclk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_flit (in_flit),
      .rd_addr (rd_addr),
      .rd_flit (rd_flit)
   );

   // Registered slice toward the consumer
   output_stage u_out (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .empty     (empty),
      .rd_flit   (rd_flit),
      .fetch     (fetch),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

endmodule

`default_nettype wire

// ==== rtl/fifo_pointers.sv ====
`default_nettype none

module fifo_pointers #(
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic                  wr_en,
   input  logic                  commit,
   input  logic                  rollback,
   input  logic                  fetch,
   output logic [DEPTH_LOG2-1:0] wr_addr,
   output logic [DEPTH_LOG2-1:0] rd_addr,
   output logic                  full,
   output logic                  empty
);

   // Extra top bit tells a full buffer from an empty one
   typedef logic [DEPTH_LOG2:0] ptr_t;

   // Leading pointer, moves with every stored flit
   ptr_t wr_spec;
   // Lagging pointer, end of the last whole packet
   ptr_t wr_commit;
   // Next flit for the output slice
   ptr_t rd_ptr;

   ptr_t wr_spec_next;
   ptr_t rd_ptr_next;

   assign wr_spec_next = wr_spec + 1'b1;
   assign rd_ptr_next  = rd_ptr + 1'b1;

   // Read pointer, one step per fetch
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         rd_ptr <= '0;
      end else if (fetch) begin
         rd_ptr <= rd_ptr_next;
      end
   end

   // Speculative write pointer
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_spec <= '0;
      end else if (rollback) begin
         // Back to the end of the last committed packet
         wr_spec <= wr_commit;
      end else if (wr_en) begin
         wr_spec <= wr_spec_next;
      end
   end

   // Committed write pointer
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_commit <= '0;
      end else if (commit) begin
         // Include the tail flit written on this edge
         if (wr_en) begin
            wr_commit <= wr_spec_next;
         end else begin
            wr_commit <= wr_spec;
         end
      end
   end

   // RAM addresses drop the wrap bit
   assign wr_addr = wr_spec[DEPTH_LOG2-1:0];
   assign rd_addr = rd_ptr[DEPTH_LOG2-1:0];

   // Write side sees every buffered flit, committed or not
   assign full = (wr_spec[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0])
              && (wr_spec[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

   // Read side sees only whole packets
   assign empty = (wr_commit == rd_ptr);

endmodule

`default_nettype wire

// ==== rtl/output_stage.sv ====
`default_nettype none

module output_stage (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic                  empty,
   input  axis_fifo_pkg::flit_t  rd_flit,
   output logic                  fetch,
   output axis_fifo_pkg::flit_t  out_flit,
   output logic                  out_valid,
   input  logic                  out_ready
);

   logic xfer;

   // Current beat leaves on this edge
   assign xfer = out_valid && out_ready;

   // Refill when the slot is free or being freed
   // Gives one flit per cycle in steady state
   assign fetch = !empty && (!out_valid || xfer);

   // Valid bit of the slice
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         out_valid <= 1'b0;
      end else if (fetch) begin
         out_valid <= 1'b1;
      end else if (xfer) begin
         // Drained with nothing behind it
         out_valid <= 1'b0;
      end
   end

   // Payload register
   // Only loads on fetch, so it holds under back-pressure
   always_ff @(posedge aclk) begin
      if (fetch) begin
         out_flit <= rd_flit;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/packet_admit_fsm.sv ====
`default_nettype none

module packet_admit_fsm (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic                  in_valid,
   input  axis_fifo_pkg::flit_t  in_flit,
   input  logic                  full,
   output logic                  ready,
   output logic                  wr_en,
   output logic                  commit,
   output logic                  rollback,
   output logic                  dropped
);

   import axis_fifo_pkg::*;

   admit_state_t state;
   admit_state_t state_next;
   logic         accept;
   logic         poisoned;
   logic         drop_now;

   // Input never stalls, ready only held low in reset
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         ready <= 1'b0;
      end else begin
         ready <= 1'b1;
      end
   end

   // Beat handshake on the input stream
   assign accept   = in_valid && ready;
   assign poisoned = in_flit.user[ERROR_BIT];

   // Admission decision per accepted flit
   always_comb begin
      state_next = state;
      wr_en      = 1'b0;
      commit     = 1'b0;
      rollback   = 1'b0;
      drop_now   = 1'b0;
      if (accept) begin
         case (state)
            ST_IDLE, ST_STORE: begin
               if (poisoned || full) begin
                  // Throw away what is buffered of this packet
                  rollback   = 1'b1;
                  drop_now   = 1'b1;
                  state_next = in_flit.last ? ST_IDLE : ST_DISCARD;
               end else begin
                  wr_en = 1'b1;
                  // Tail write makes the packet visible
                  commit     = in_flit.last;
                  state_next = in_flit.last ? ST_IDLE : ST_STORE;
               end
            end
            ST_DISCARD: begin
               // Swallow the rest up to tlast
               if (in_flit.last) begin
                  state_next = ST_IDLE;
               end
            end
            default: state_next = ST_IDLE;
         endcase
      end
   end

   // State and one-cycle drop pulse
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state   <= ST_IDLE;
         dropped <= 1'b0;
      end else begin
         state   <= state_next;
         dropped <= drop_now;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/packet_ram.sv ====
`default_nettype none

module packet_ram #(
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                  aclk,
   input  logic                  wr_en,
   input  logic [DEPTH_LOG2-1:0] wr_addr,
   input  axis_fifo_pkg::flit_t  wr_flit,
   input  logic [DEPTH_LOG2-1:0] rd_addr,
   output axis_fifo_pkg::flit_t  rd_flit
);

   import axis_fifo_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   // Whole flit per entry, side channels included
   flit_t mem [DEPTH];

   // Synchronous write port
   always_ff @(posedge aclk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_flit;
      end
   end

   // Asynchronous read, maps to LUT RAM
   assign rd_flit = mem[rd_addr];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the packet FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f build.f --top-module tb_axis_packet_fifo \
   --Mdir obj_dir -o sim_tb

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// ==== testbench/tb_axis_packet_fifo.sv ====
`default_nettype none

module tb_axis_packet_fifo;

   timeunit 1ns;
   timeprecision 100ps;

   import axis_fifo_pkg::*;

   localparam int DEPTH_LOG2  = 4;
   localparam int DEPTH       = 16;
   localparam int NUM_PACKETS = 80;
   localparam int TIMEOUT     = 2000;

   logic  aclk = 1'b0;
   logic  aresetn;
   flit_t in_flit;
   logic  in_valid;
   logic  in_ready;
   flit_t out_flit;
   logic  out_valid;
   logic  out_ready;
   logic  packet_dropped;

   // Stimulus state
   logic [31:0] rng_state;
   logic        hold_output;
   int          drops_sent;

   // Reference model updated on the clock edge
   flit_t        exp_q[$];
   flit_t        spec_q[$];
   admit_state_t model_state;
   int           occ;
   logic         model_drop;

   // Registered model outputs seen by the assertions
   flit_t exp_head;
   int    exp_count;
   int    commit_total;
   int    sent_total;
   logic  drop_expect;
   int    drops_seen;
   logic  stalled_q;
   flit_t flit_q;
   logic  aresetn_q = 1'b1;

   axis_packet_fifo #(
      .DEPTH_LOG2 (DEPTH_LOG2)
   ) u_dut (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .in_flit        (in_flit),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .out_flit       (out_flit),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .packet_dropped (packet_dropped)
   );

   // 10 ns clock
   always #5 aclk = ~aclk;

   task automatic stop_run();
      $display("test failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_error(input string why);
      $display("%s", why);
      stop_run();
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] expected,
                                  input logic [127:0] actual);
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      stop_run();
   endtask

   // LCG with the Numerical Recipes constants
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Upper bits only since the low ones have short periods
   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[30:8]) % n;
   endfunction

   function automatic flit_t random_flit(input logic poison, input logic last);
      flit_t       f;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] side;
      hi   = next_rand();
      lo   = next_rand();
      side = next_rand();
      f.data = {hi, lo};
      f.keep = side[31:24];
      f.id   = side[23:20];
      f.dest = side[19:16];
      // Spare user bit random and error bit chosen by the caller
      f.user = side[15:14];
      f.user[ERROR_BIT] = poison;
      f.last = last;
      return f;
   endfunction

   // One cycle with inputs changing 1 ns after the edge
   task automatic step();
      @(posedge aclk);
      #1;
      if (hold_output) begin
         out_ready = 1'b0;
      end else begin
         out_ready = (rand_below(4) != 0);
      end
   endtask

   task automatic send_flit(input flit_t f);
      int   waited;
      logic was_ready;
      waited    = 0;
      in_flit   = f;
      in_valid  = 1'b1;
      was_ready = in_ready;
      step();
      while (!was_ready && waited < TIMEOUT) begin
         waited++;
         was_ready = in_ready;
         step();
      end
      if (!was_ready) begin
         report_error("timeout waiting for in_ready to accept a flit");
      end
      in_valid = 1'b0;
   endtask

   // poison_at below zero means a clean packet
   task automatic send_packet(input int len, input int poison_at);
      int i;
      for (i = 0; i < len; i++) begin
         // Occasional idle cycle between beats
         if (rand_below(5) == 0) begin
            in_valid = 1'b0;
            step();
         end
         send_flit(random_flit(i == poison_at, i == len - 1));
      end
   endtask

   // Conservative occupancy plus the new packet must fit
   task automatic wait_for_room(input int len);
      int waited;
      waited = 0;
      while (occ + len > DEPTH && waited < TIMEOUT) begin
         waited++;
         step();
      end
      if (occ + len > DEPTH) begin
         report_error("timeout waiting for buffer room before a packet");
      end
   endtask

   task automatic wait_for_drain();
      int waited;
      waited = 0;
      while ((occ != 0 || exp_count != 0) && waited < TIMEOUT) begin
         waited++;
         step();
      end
      if (occ != 0 || exp_count != 0) begin
         report_error("timeout waiting for the output to drain all committed packets");
      end
   endtask

   // Overlong packet into an empty buffer with the consumer stalled
   task automatic run_overflow();
      int len;
      wait_for_drain();
      hold_output = 1'b1;
      len = DEPTH + 1 + rand_below(8);
      send_packet(len, -1);
      drops_sent++;
      // Next packet must still get through
      len = 1 + rand_below(6);
      send_packet(len, -1);
      // Committed packet now sits behind a stalled consumer
      repeat (8) step();
      hold_output = 1'b0;
   endtask

   // Model of the admission rule and the expected output order
   always @(posedge aclk) begin
      if (!aresetn) begin
         exp_q.delete();
         spec_q.delete();
         model_state = ST_IDLE;
         occ         = 0;
         drop_expect  <= 1'b0;
         exp_head     <= '0;
         exp_count    <= 0;
         commit_total <= 0;
         sent_total   <= 0;
      end else begin
         model_drop = 1'b0;
         if (in_valid && in_ready) begin
            if (model_state == ST_DISCARD) begin
               if (in_flit.last) begin
                  model_state = ST_IDLE;
               end
            end else if (in_flit.user[ERROR_BIT] || (occ + spec_q.size() >= DEPTH)) begin
               // Poisoned or no room so the whole packet goes
               model_drop = 1'b1;
               spec_q.delete();
               model_state = in_flit.last ? ST_IDLE : ST_DISCARD;
            end else begin
               spec_q.push_back(in_flit);
               if (in_flit.last) begin
                  commit_total <= commit_total + spec_q.size();
                  occ = occ + spec_q.size();
                  foreach (spec_q[k]) begin
                     exp_q.push_back(spec_q[k]);
                  end
                  spec_q.delete();
                  model_state = ST_IDLE;
               end else begin
                  model_state = ST_STORE;
               end
            end
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() != 0) begin
               exp_q.delete(0);
               occ = occ - 1;
            end
            sent_total <= sent_total + 1;
         end
         drop_expect <= model_drop;
         exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
         exp_count   <= exp_q.size();
      end
   end

   // Previous output state for the hold check
   always @(posedge aclk) begin
      aresetn_q <= aresetn;
      flit_q    <= out_flit;
      if (!aresetn) begin
         stalled_q  <= 1'b0;
         drops_seen <= 0;
      end else begin
         stalled_q <= out_valid && !out_ready;
         if (packet_dropped) begin
            drops_seen <= drops_seen + 1;
         end
      end
   end

   // Something leaves only if the model expects it
   check_no_extra: assert property (@(posedge aclk) disable iff (!aresetn)
      (out_valid && out_ready) |-> (exp_count != 0))
      else report_error("output transferred a flit that no committed packet accounts for");

   // Order and contents of every transferred flit
   check_flit: assert property (@(posedge aclk) disable iff (!aresetn)
      (out_valid && out_ready && exp_count != 0) |-> (out_flit == exp_head))
      else report_mismatch("out_flit", 128'($sampled(exp_head)), 128'($sampled(out_flit)));

   // One pulse in the cycle after the offending flit
   check_drop: assert property (@(posedge aclk) disable iff (!aresetn)
      packet_dropped == drop_expect)
      else report_mismatch("packet_dropped", 128'($sampled(drop_expect)),
                           128'($sampled(packet_dropped)));

   // Stalled beat stays put
   check_hold_valid: assert property (@(posedge aclk) disable iff (!aresetn)
      stalled_q |-> out_valid)
      else report_error("out_valid fell while out_ready was held low");

   check_hold_flit: assert property (@(posedge aclk) disable iff (!aresetn)
      stalled_q |-> (out_flit == flit_q))
      else report_mismatch("out_flit", 128'($sampled(flit_q)), 128'($sampled(out_flit)));

   // Nothing shows before its tlast is in
   check_store_forward: assert property (@(posedge aclk) disable iff (!aresetn)
      out_valid |-> (sent_total < commit_total))
      else report_error("out_valid rose for a packet whose tlast was not yet accepted");

   // Outputs quiet once a reset edge has been seen
   check_in_reset: assert property (@(posedge aclk)
      (!aresetn && !aresetn_q) |-> (!in_ready && !out_valid && !packet_dropped))
      else report_error("in_ready, out_valid or packet_dropped high during reset");

   check_after_reset: assert property (@(posedge aclk)
      (aresetn && !aresetn_q) |-> (!out_valid && !packet_dropped))
      else report_error("out_valid or packet_dropped high on the first cycle after reset");

   initial begin
      int pkt;
      int len;
      int poison_at;
      int waited;
      rng_state   = 32'd62528;
      hold_output = 1'b0;
      drops_sent  = 0;
      aresetn     = 1'b0;
      in_valid    = 1'b0;
      in_flit     = '0;
      out_ready   = 1'b0;

      // Five cycles of reset
      repeat (5) step();
      aresetn = 1'b1;

      waited = 0;
      while (!in_ready && waited < TIMEOUT) begin
         waited++;
         step();
      end
      if (!in_ready) begin
         report_error("timeout waiting for in_ready after reset");
      end

      // Random traffic with overflow bursts mixed in
      for (pkt = 0; pkt < NUM_PACKETS; pkt++) begin
         if (pkt % 20 == 10) begin
            run_overflow();
         end
         len = 1 + rand_below(DEPTH);
         poison_at = -1;
         if (rand_below(6) == 0) begin
            poison_at = rand_below(len);
         end
         wait_for_room(len);
         send_packet(len, poison_at);
         if (poison_at >= 0) begin
            drops_sent++;
         end
      end

      hold_output = 1'b0;
      wait_for_drain();
      // Let the last drop pulse reach the counter
      repeat (3) step();

      check_idle: assert (!out_valid)
         else report_error("out_valid still high after all packets drained");
      check_drop_count: assert (drops_seen == drops_sent)
         else report_mismatch("drop count", 128'(drops_sent), 128'(drops_seen));

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire
